//--- Bender.yml
package:
  name: dmme

sources:
  - common/dmme_data_pkg.sv
  - common/dmme_ctrl_pkg.sv
  - common/feed_if.sv
  - hw/mac_ctrl.sv
  - systolic/operand_skew.sv
  - systolic/pe.sv
  - hw/dmme_top.sv
  - target: test
    files:
      - verification/dmme_checker.sv
      - verification/tb_dmme.sv

//--- common/dmme_ctrl_pkg.sv
package dmme_ctrl_pkg;

    import dmme_data_pkg::*;

    typedef enum logic [1:0] {
        idle = 2'd0,
        mac  = 2'd1,
        done = 2'd2
    } ctrl_state_t;

    // skew depth plus one cycle for the forwarding register
    localparam int unsigned mac_cycles = dim + dim - 1 + 1;

endpackage

//--- common/dmme_data_pkg.sv
package dmme_data_pkg;

    // matrix element
    localparam int unsigned elem_w = 8;

    // two full-range products need 17 bits, one spare
    localparam int unsigned acc_w = 18;

    // array edge length
    localparam int unsigned dim = 2;

    typedef logic [elem_w-1:0] elem_t;
    typedef logic [acc_w-1:0]  acc_t;

endpackage

//--- common/feed_if.sv
`timescale 1ns/1ps

interface feed_if
    import dmme_data_pkg::*;
();

    elem_t a_row0;  // left edge, row 0
    elem_t a_row1;  // left edge, row 1
    elem_t b_col0;  // top edge, column 0
    elem_t b_col1;  // top edge, column 1

    modport source (
        output a_row0,
        output a_row1,
        output b_col0,
        output b_col1
    );

    modport array (
        input a_row0,
        input a_row1,
        input b_col0,
        input b_col1
    );

endinterface

//--- hw/dmme_top.sv
`timescale 1ns/1ps

module dmme_top
    import dmme_data_pkg::*;
(
    input  logic  clk_in,
    input  logic  rst,
    input  logic  req,
    output logic  ack,
    input  elem_t a00,
    input  elem_t a01,
    input  elem_t a10,
    input  elem_t a11,
    input  elem_t b00,
    input  elem_t b01,
    input  elem_t b10,
    input  elem_t b11,
    output acc_t  c00,
    output acc_t  c01,
    output acc_t  c10,
    output acc_t  c11
);

    logic       load;
    logic       in_mac;
    logic [1:0] step;

    elem_t a_00_01;  // pe00 -> pe01
    elem_t b_00_10;  // pe00 -> pe10
    elem_t b_01_11;  // pe01 -> pe11
    elem_t a_10_11;  // pe10 -> pe11

    feed_if feed ();

    mac_ctrl u_ctrl (
        .clk_in (clk_in),
        .rst    (rst),
        .req    (req),
        .ack    (ack),
        .load   (load),
        .in_mac (in_mac),
        .step   (step)
    );

    operand_skew u_skew (
        .clk_in (clk_in),
        .rst    (rst),
        .load   (load),
        .in_mac (in_mac),
        .step   (step),
        .a00    (a00),
        .a01    (a01),
        .a10    (a10),
        .a11    (a11),
        .b00    (b00),
        .b01    (b01),
        .b10    (b10),
        .b11    (b11),
        .feed   (feed.source)
    );

    pe u_pe00 (
        .clk_in (clk_in),
        .rst    (rst),
        .clear  (load),
        .a_in   (feed.a_row0),
        .b_in   (feed.b_col0),
        .a_out  (a_00_01),
        .b_out  (b_00_10),
        .sum    (c00)
    );

    pe u_pe01 (
        .clk_in (clk_in),
        .rst    (rst),
        .clear  (load),
        .a_in   (a_00_01),
        .b_in   (feed.b_col1),
        .a_out  (),        // right edge
        .b_out  (b_01_11),
        .sum    (c01)
    );

    pe u_pe10 (
        .clk_in (clk_in),
        .rst    (rst),
        .clear  (load),
        .a_in   (feed.a_row1),
        .b_in   (b_00_10),
        .a_out  (a_10_11),
        .b_out  (),        // bottom edge
        .sum    (c10)
    );

    pe u_pe11 (
        .clk_in (clk_in),
        .rst    (rst),
        .clear  (load),
        .a_in   (a_10_11),
        .b_in   (b_01_11),
        .a_out  (),
        .b_out  (),
        .sum    (c11)
    );

endmodule

//--- hw/mac_ctrl.sv
`timescale 1ns/1ps

module mac_ctrl
    import dmme_ctrl_pkg::*;
(
    input  logic       clk_in,
    input  logic       rst,
    input  logic       req,
    output logic       ack,
    output logic       load,
    output logic       in_mac,
    output logic [1:0] step
);

    ctrl_state_t state;
    ctrl_state_t state_nxt;
    logic        last_step;

    assign last_step = (step == 2'(mac_cycles - 1));
    assign load      = (state == idle) && req;  // accept cycle
    assign in_mac    = (state == mac);

    always_comb begin
        state_nxt = state;
        case (state)
            idle: begin
                if (req) begin
                    state_nxt = mac;
                end
            end
            mac: begin
                if (last_step) begin
                    state_nxt = done;
                end
            end
            done: begin
                // wait for the source to release req
                if (!req) begin
                    state_nxt = idle;
                end
            end
            default: begin
                state_nxt = idle;
            end
        endcase
    end

    always_ff @(posedge clk_in or negedge rst) begin
        if (!rst) begin
            state <= idle;
        end else begin
            state <= state_nxt;
        end
    end

    always_ff @(posedge clk_in or negedge rst) begin
        if (!rst) begin
            step <= 2'd0;
        end else if (state == mac) begin
            step <= step + 2'd1;  // wraps on the last cycle
        end else begin
            step <= 2'd0;
        end
    end

    // sums are settled once done is reached, ack follows a cycle later
    always_ff @(posedge clk_in or negedge rst) begin
        if (!rst) begin
            ack <= 1'b0;
        end else begin
            ack <= (state == done) && req;
        end
    end

    // never flag results while the array is busy
    assert property (@(posedge clk_in) disable iff (!rst)
        in_mac |-> !ack);

    // source keeps the request up until the results are flagged
    assert property (@(posedge clk_in) disable iff (!rst)
        load |-> (req until_with ack));

endmodule

//--- systolic/operand_skew.sv
`timescale 1ns/1ps

module operand_skew
    import dmme_data_pkg::*;
(
    input  logic          clk_in,
    input  logic          rst,
    input  logic          load,
    input  logic          in_mac,
    input  logic [1:0]    step,
    input  elem_t         a00,
    input  elem_t         a01,
    input  elem_t         a10,
    input  elem_t         a11,
    input  elem_t         b00,
    input  elem_t         b01,
    input  elem_t         b10,
    input  elem_t         b11,
    feed_if.source        feed
);

    elem_t a_q [dim][dim];
    elem_t b_q [dim][dim];

    // job operands, captured once per job
    always_ff @(posedge clk_in) begin
        if (load) begin
            a_q[0][0] <= a00;
            a_q[0][1] <= a01;
            a_q[1][0] <= a10;
            a_q[1][1] <= a11;
            b_q[0][0] <= b00;
            b_q[0][1] <= b01;
            b_q[1][0] <= b10;
            b_q[1][1] <= b11;
        end
    end

    // row 1 and column 1 run one step behind row 0 and column 0
    always_comb begin
        feed.a_row0 = '0;
        feed.a_row1 = '0;
        feed.b_col0 = '0;
        feed.b_col1 = '0;
        if (in_mac) begin
            case (step)
                2'd0: begin
                    feed.a_row0 = a_q[0][0];
                    feed.b_col0 = b_q[0][0];
                end
                2'd1: begin
                    feed.a_row0 = a_q[0][1];
                    feed.b_col0 = b_q[1][0];
                    feed.a_row1 = a_q[1][0];
                    feed.b_col1 = b_q[0][1];
                end
                2'd2: begin
                    feed.a_row1 = a_q[1][1];
                    feed.b_col1 = b_q[1][1];
                end
                default: begin
                    // last cycle only drains the forwarding registers
                end
            endcase
        end
    end

    assert property (@(posedge clk_in) disable iff (!rst)
        !in_mac |-> (feed.a_row0 == '0 && feed.a_row1 == '0 &&
                     feed.b_col0 == '0 && feed.b_col1 == '0));

endmodule

//--- systolic/pe.sv
`timescale 1ns/1ps

module pe
    import dmme_data_pkg::*;
(
    input  logic  clk_in,
    input  logic  rst,
    input  logic  clear,
    input  elem_t a_in,
    input  elem_t b_in,
    output elem_t a_out,
    output elem_t b_out,
    output acc_t  sum
);

    acc_t prod;

    assign prod = acc_t'(a_in) * acc_t'(b_in);

    // output stationary, sum stays here for the whole job
    always_ff @(posedge clk_in or negedge rst) begin
        if (!rst) begin
            sum <= '0;
        end else if (clear) begin
            sum <= '0;
        end else begin
            sum <= sum + prod;  // zero operands outside mac keep it stable
        end
    end

    // pass operands to the right and lower neighbours
    always_ff @(posedge clk_in or negedge rst) begin
        if (!rst) begin
            a_out <= '0;
            b_out <= '0;
        end else if (clear) begin
            a_out <= '0;
            b_out <= '0;
        end else begin
            a_out <= a_in;
            b_out <= b_in;
        end
    end

endmodule

//--- verification/dmme_checker.sv
`timescale 1ns/1ps

module dmme_checker
    import dmme_data_pkg::*;
(
    input  logic        clk_in,
    input  logic        rst,
    input  logic        req,
    input  logic        ack,
    input  elem_t       a00,
    input  elem_t       a01,
    input  elem_t       a10,
    input  elem_t       a11,
    input  elem_t       b00,
    input  elem_t       b01,
    input  elem_t       b10,
    input  elem_t       b11,
    input  acc_t        c00,
    input  acc_t        c01,
    input  acc_t        c10,
    input  acc_t        c11,
    input  logic [2:0]  test_id,
    output int unsigned tests_run,
    output int unsigned errors
);

    elem_t       a_cap [dim][dim];
    elem_t       b_cap [dim][dim];
    logic        req_q;
    logic        ack_q;
    logic        reset_seen;
    int unsigned job_errors;
    int unsigned held_cycles;

    initial begin
        tests_run  = 0;
        errors     = 0;
        reset_seen = 1'b0;
        job_errors = 0;
    end

    function automatic string test_name(input logic [2:0] id);
        case (id)
            3'd1: return "identity";
            3'd2: return "full_range";
            3'd3: return "random";
            3'd4: return "acc_clear";
            3'd5: return "hold";
            default: return "unknown";
        endcase
    endfunction

    function automatic acc_t c_out(input int i, input int j);
        case ({i[0], j[0]})
            2'b00: return c00;
            2'b01: return c01;
            2'b10: return c10;
            default: return c11;
        endcase
    endfunction

    // C[i][j] = sum over k of A[i][k] * B[k][j]
    function automatic acc_t expected_entry(input int i, input int j);
        acc_t acc;
        acc = '0;
        for (int k = 0; k < dim; k++) begin
            acc = acc + acc_t'(a_cap[i][k]) * acc_t'(b_cap[k][j]);
        end
        return acc;
    endfunction

    always @(posedge clk_in or negedge rst) begin
        if (!rst) begin
            req_q <= 1'b0;
            ack_q <= 1'b0;
        end else begin
            req_q <= req;
            ack_q <= ack;

            if (!reset_seen) begin
                reset_seen = 1'b1;
                tests_run  = tests_run + 1;
                if (ack) begin
                    $display("reset: ack is high right after reset");
                    errors = errors + 1;
                end
                for (int i = 0; i < dim; i++) begin
                    for (int j = 0; j < dim; j++) begin
                        if (c_out(i, j) != '0) begin
                            $display("** Error reset: c%0d%0d expected 0, actual %0d",
                                     i, j, c_out(i, j));
                            errors = errors + 1;
                        end
                    end
                end
                $display("test reset: done");
            end

            if (req && !req_q) begin  // operands are stable from here until ack
                a_cap[0][0] = a00;
                a_cap[0][1] = a01;
                a_cap[1][0] = a10;
                a_cap[1][1] = a11;
                b_cap[0][0] = b00;
                b_cap[0][1] = b01;
                b_cap[1][0] = b10;
                b_cap[1][1] = b11;
                job_errors  = 0;
                held_cycles = 0;
            end

            // results must match the product on every cycle ack is high
            if (ack) begin
                for (int i = 0; i < dim; i++) begin
                    for (int j = 0; j < dim; j++) begin
                        if (c_out(i, j) != expected_entry(i, j)) begin
                            $display("** Error %s: c%0d%0d expected %0d, actual %0d",
                                     test_name(test_id), i, j,
                                     expected_entry(i, j), c_out(i, j));
                            job_errors = job_errors + 1;
                        end
                    end
                end
            end

            if (ack) begin
                held_cycles = held_cycles + 1;
            end

            if (ack_q && req_q && !ack) begin
                $display("%s: ack dropped while req was still high", test_name(test_id));
                job_errors = job_errors + 1;
            end

            if (ack_q && !ack) begin  // job finished
                tests_run = tests_run + 1;
                errors    = errors + job_errors;
                $display("test %s: %0d errors, ack high %0d cycles",
                         test_name(test_id), job_errors, held_cycles);
            end
        end
    end

endmodule

//--- verification/tb_dmme.sv
`timescale 1ns/1ps

module tb_dmme
    import dmme_data_pkg::*;
();

    localparam int unsigned n_random    = 30;
    localparam int unsigned n_jobs      = n_random + 5;
    localparam int unsigned job_budget  = 40;  // n_jobs plus spare
    localparam int unsigned cyc_per_job = 12;
    // twice the budgeted job time, plus reset
    localparam int unsigned max_cycles  = 2 * job_budget * cyc_per_job + 40;

    logic        clk_in;
    logic        rst;
    logic        req;
    logic        ack;
    elem_t       a00;
    elem_t       a01;
    elem_t       a10;
    elem_t       a11;
    elem_t       b00;
    elem_t       b01;
    elem_t       b10;
    elem_t       b11;
    acc_t        c00;
    acc_t        c01;
    acc_t        c10;
    acc_t        c11;
    logic [2:0]  test_id;
    int unsigned tests_run;
    int unsigned errors;
    int unsigned cycles = 0;

    dmme_top u_dmme_top (
        .clk_in (clk_in),
        .rst    (rst),
        .req    (req),
        .ack    (ack),
        .a00    (a00),
        .a01    (a01),
        .a10    (a10),
        .a11    (a11),
        .b00    (b00),
        .b01    (b01),
        .b10    (b10),
        .b11    (b11),
        .c00    (c00),
        .c01    (c01),
        .c10    (c10),
        .c11    (c11)
    );

    dmme_checker u_checker (
        .clk_in    (clk_in),
        .rst       (rst),
        .req       (req),
        .ack       (ack),
        .a00       (a00),
        .a01       (a01),
        .a10       (a10),
        .a11       (a11),
        .b00       (b00),
        .b01       (b01),
        .b10       (b10),
        .b11       (b11),
        .c00       (c00),
        .c01       (c01),
        .c10       (c10),
        .c11       (c11),
        .test_id   (test_id),
        .tests_run (tests_run),
        .errors    (errors)
    );

    initial begin
        clk_in = 1'b0;
        forever #10 clk_in = ~clk_in;
    end

    always @(posedge clk_in) begin
        cycles <= cycles + 1;
    end

    initial begin
        wait (cycles >= max_cycles);
        $display("timeout: run did not finish within %0d cycles", max_cycles);
        $display("*** TEST FAILED ***");
        $finish;
    end

    // one four-phase transfer, hold keeps req up after ack
    task automatic run_job(
        input logic [2:0]  id,
        input elem_t       x00, x01, x10, x11,
        input elem_t       y00, y01, y10, y11,
        input int unsigned hold
    );
        @(posedge clk_in);
        a00     <= x00;
        a01     <= x01;
        a10     <= x10;
        a11     <= x11;
        b00     <= y00;
        b01     <= y01;
        b10     <= y10;
        b11     <= y11;
        test_id <= id;
        req     <= 1'b1;
        @(posedge clk_in);
        while (!ack) @(posedge clk_in);
        repeat (hold) @(posedge clk_in);
        req <= 1'b0;
        @(posedge clk_in);
        while (ack) @(posedge clk_in);
    endtask

    initial begin
        void'($urandom(8547));
        rst     = 1'b0;
        req     = 1'b0;
        a00     = '0;
        a01     = '0;
        a10     = '0;
        a11     = '0;
        b00     = '0;
        b01     = '0;
        b10     = '0;
        b11     = '0;
        test_id = '0;
        repeat (3) @(posedge clk_in);
        rst <= 1'b1;
        repeat (2) @(posedge clk_in);  // checker looks at the idle state here

        run_job(3'd1, 8'd12, 8'd34, 8'd56, 8'd78, 8'd1, 8'd0, 8'd0, 8'd1, 0);
        run_job(3'd2, 8'd255, 8'd255, 8'd255, 8'd255, 8'd255, 8'd255, 8'd255, 8'd255, 0);

        for (int n = 0; n < n_random; n++) begin
            run_job(3'd3,
                    elem_t'($urandom), elem_t'($urandom), elem_t'($urandom), elem_t'($urandom),
                    elem_t'($urandom), elem_t'($urandom), elem_t'($urandom), elem_t'($urandom),
                    0);
        end

        // large job first, a running total would show up in the small one
        run_job(3'd4, 8'd200, 8'd190, 8'd180, 8'd170, 8'd160, 8'd150, 8'd140, 8'd130, 0);
        run_job(3'd4, 8'd1, 8'd2, 8'd3, 8'd4, 8'd5, 8'd6, 8'd7, 8'd8, 0);

        run_job(3'd5, 8'd9, 8'd87, 8'd65, 8'd43, 8'd21, 8'd3, 8'd99, 8'd250, 6);

        repeat (3) @(posedge clk_in);
        $display("tests run: %0d, errors: %0d", tests_run, errors);
        if (errors == 0 && tests_run == n_jobs + 1) begin
            $display("*** TEST PASSED ***");
        end else begin
            if (tests_run != n_jobs + 1) begin
                $display("expected %0d finished tests but saw %0d", n_jobs + 1, tests_run);
            end
            $display("*** TEST FAILED ***");
        end
        $finish;
    end

endmodule

//--- vlog.f
common/dmme_data_pkg.sv
common/dmme_ctrl_pkg.sv
common/feed_if.sv
hw/mac_ctrl.sv
systolic/operand_skew.sv
systolic/pe.sv
hw/dmme_top.sv
verification/dmme_checker.sv
verification/tb_dmme.sv
